// File: logic/dm_ctrl_regs.sv
`timescale 1ns/100ps

module dm_ctrl_regs #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_fire_i,
  input  dmi_pkg::dmi_op_e                     req_op_i,
  input  logic [dmi_pkg::DmiAddrWidth-1:0]     req_addr_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0]     req_data_i,
  input  dm_reg_pkg::dmstatus_t                dmstatus_i,
  input  logic [31:0]                          haltsum0_i,
  input  logic                                 sel_resumeack_i,
  output logic [31:0]                          rdata_o,
  output logic [dm_reg_pkg::HartSelWidth-1:0]  hartsel_o,
  output logic                                 haltreq_o,
  output logic                                 resumereq_o,
  output logic                                 ackhavereset_o,
  output logic                                 ndmreset_o,
  output logic                                 dmactive_o,
  output logic                                 clear_resumeack_o
);

  import dmi_pkg::*;
  import dm_reg_pkg::*;

  dm_csr_e    csr_addr;
  dm_word_u   wdata;
  dm_word_u   rword;
  dmcontrol_t dmcontrol_d, dmcontrol_q;
  logic       ctrl_write;
  logic       hart_exists;

  assign csr_addr   = dm_csr_e'(req_addr_i);
  assign wdata.raw  = req_data_i;
  assign ctrl_write = req_fire_i && (req_op_i == DmiWrite) && (csr_addr == DMControl);

  assign hartsel_o   = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign hart_exists = (32'(hartsel_o) < NrHarts);

  // --------------------------------------------------
  // dmcontrol next state
  // --------------------------------------------------
  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    ackhavereset_o    = 1'b0;
    clear_resumeack_o = 1'b0;

    if (ctrl_write) begin
      dmcontrol_d = wdata.ctrl;
      // ack only reaches a hart that is there
      ackhavereset_o    = dmcontrol_q.dmactive & wdata.ctrl.ackhavereset & hart_exists;
      clear_resumeack_o = dmcontrol_q.dmactive & ~dmcontrol_q.resumereq
                          & wdata.ctrl.resumereq;
    end

    // fields without function read as zero
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.zero0           = '0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;

    // hart has acknowledged the resume
    if (dmcontrol_q.resumereq && sel_resumeack_i) begin
      dmcontrol_d.resumereq = 1'b0;
    end

    // soft reset while inactive, only dmactive can be written
    if (!dmcontrol_q.dmactive) begin
      dmcontrol_d          = '0;
      dmcontrol_d.dmactive = ctrl_write & wdata.ctrl.dmactive;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
    end else begin
      dmcontrol_q <= dmcontrol_d;
    end
  end

  assign haltreq_o   = dmcontrol_q.haltreq;
  assign resumereq_o = dmcontrol_q.resumereq;
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;

  // --------------------------------------------------
  // read word, zero for writes and nops
  // --------------------------------------------------
  always_comb begin
    rword.raw = '0;
    if (req_op_i == DmiRead) begin
      case (csr_addr)
        DMControl: rword.ctrl   = dmcontrol_q;
        DMStatus:  rword.status = dmstatus_i;
        HaltSum0:  rword.raw    = haltsum0_i;
        default:   rword.raw    = '0;
      endcase
    end
  end

  assign rdata_o = rword.raw;

endmodule

// File: logic/dm_hart_slice.sv
`timescale 1ns/100ps

module dm_hart_slice #(
  parameter int unsigned HartIdx = 0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [dm_reg_pkg::HartSelWidth-1:0]  hartsel_i,
  input  logic                                 haltreq_i,
  input  logic                                 resumereq_i,
  input  logic                                 ackhavereset_i,
  input  logic                                 ndmreset_i,
  input  logic                                 halted_i,
  input  logic                                 unavailable_i,
  input  logic                                 resumeack_i,
  output logic                                 haltreq_o,
  output logic                                 resumereq_o,
  output logic                                 havereset_o,
  output logic                                 halted_o,
  output logic                                 running_o
);

  import dm_reg_pkg::*;

  logic selected;
  logic havereset_q;

  assign selected = (hartsel_i == HartSelWidth'(HartIdx));

  // requests only go to the selected hart
  assign haltreq_o   = selected & haltreq_i;
  // a hart that has already acked does not see the request again
  assign resumereq_o = selected & resumereq_i & ~resumeack_i;

  // unavailable wins over halted and running
  assign halted_o  = halted_i & ~unavailable_i;
  assign running_o = ~halted_i & ~unavailable_i;

  // ndmreset has priority over the ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q <= 1'b1;
    end else if (ndmreset_i) begin
      havereset_q <= 1'b1;
    end else if (ackhavereset_i && selected) begin
      havereset_q <= 1'b0;
    end
  end

  assign havereset_o = havereset_q;

endmodule

// File: logic/dm_reg_pkg.sv
package dm_reg_pkg;

  // --------------------------------------------------
  // register addresses
  // --------------------------------------------------
  typedef enum logic [6:0] {
    DMControl = 7'h10,
    DMStatus  = 7'h11,
    HaltSum0  = 7'h40
  } dm_csr_e;

  localparam int unsigned HartSelWidth = 20;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion013 = 4'h2;

  // --------------------------------------------------
  // field layouts
  // --------------------------------------------------
  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       devtreeaddrvalid;
    logic [3:0] version;
  } dmstatus_t;

  // one data word, seen raw or through either register layout
  typedef union packed {
    logic [31:0] raw;
    dmcontrol_t  ctrl;
    dmstatus_t   status;
  } dm_word_u;

endpackage

// File: logic/dm_status_gather.sv
`timescale 1ns/100ps

module dm_status_gather #(
  parameter int unsigned NrHarts = 1
) (
  input  logic [dm_reg_pkg::HartSelWidth-1:0]  hartsel_i,
  input  logic [NrHarts-1:0]                   halted_i,
  input  logic [NrHarts-1:0]                   running_i,
  input  logic [NrHarts-1:0]                   unavailable_i,
  input  logic [NrHarts-1:0]                   resumeack_i,
  input  logic [NrHarts-1:0]                   havereset_i,
  output dm_reg_pkg::dmstatus_t                dmstatus_o,
  output logic [31:0]                          haltsum0_o,
  output logic                                 sel_resumeack_o
);

  import dm_reg_pkg::*;

  // number of 32-hart groups
  localparam int unsigned NrGroups = (NrHarts + 31) / 32;

  logic                    sel_halted, sel_running, sel_unavail;
  logic                    sel_resumeack, sel_havereset;
  logic                    nonexistent;
  logic [NrGroups*32-1:0]  halted_flat;
  logic [14:0]             group_idx;

  assign nonexistent = (32'(hartsel_i) >= NrHarts);

  // selected hart, all zero if none matches
  always_comb begin
    sel_halted    = 1'b0;
    sel_running   = 1'b0;
    sel_unavail   = 1'b0;
    sel_resumeack = 1'b0;
    sel_havereset = 1'b0;
    for (int unsigned k = 0; k < NrHarts; k++) begin
      if (hartsel_i == HartSelWidth'(k)) begin
        sel_halted    = halted_i[k];
        sel_running   = running_i[k];
        sel_unavail   = unavailable_i[k];
        sel_resumeack = resumeack_i[k];
        sel_havereset = havereset_i[k];
      end
    end
  end

  // --------------------------------------------------
  // dmstatus, one hart selected so any equals all
  // --------------------------------------------------
  always_comb begin
    dmstatus_o                = '0;
    dmstatus_o.version        = DbgVersion013;
    dmstatus_o.authenticated  = 1'b1;
    dmstatus_o.allhavereset   = sel_havereset;
    dmstatus_o.anyhavereset   = sel_havereset;
    dmstatus_o.allresumeack   = sel_resumeack;
    dmstatus_o.anyresumeack   = sel_resumeack;
    dmstatus_o.allnonexistent = nonexistent;
    dmstatus_o.anynonexistent = nonexistent;
    dmstatus_o.allunavail     = sel_unavail;
    dmstatus_o.anyunavail     = sel_unavail;
    dmstatus_o.allrunning     = sel_running;
    dmstatus_o.anyrunning     = sel_running;
    dmstatus_o.allhalted      = sel_halted;
    dmstatus_o.anyhalted      = sel_halted;
  end

  assign sel_resumeack_o = sel_resumeack;

  // haltsum0 shows the group that hartsel points into
  assign group_idx = hartsel_i[19:5];

  always_comb begin
    halted_flat              = '0;
    halted_flat[NrHarts-1:0] = halted_i;
    haltsum0_o               = '0;
    if (group_idx < 15'(NrGroups)) begin
      haltsum0_o = halted_flat[group_idx*32 +: 32];
    end
  end

endmodule

// File: logic/dm_top.sv
`timescale 1ns/100ps

module dm_top #(
  parameter int unsigned NrHarts   = 1,
  parameter int unsigned RespDepth = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              dmi_req_valid_i,
  output logic                              dmi_req_ready_o,
  input  logic [dmi_pkg::DmiAddrWidth-1:0]  dmi_req_addr_i,
  input  dmi_pkg::dmi_op_e                  dmi_req_op_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0]  dmi_req_data_i,
  output logic                              dmi_resp_valid_o,
  input  logic                              dmi_resp_ready_i,
  output logic [dmi_pkg::DmiDataWidth-1:0]  dmi_resp_data_o,
  input  logic [NrHarts-1:0]                halted_i,
  input  logic [NrHarts-1:0]                unavailable_i,
  input  logic [NrHarts-1:0]                resumeack_i,
  output logic [NrHarts-1:0]                haltreq_o,
  output logic [NrHarts-1:0]                resumereq_o,
  output logic                              ndmreset_o,
  output logic                              dmactive_o,
  output logic                              clear_resumeack_o
);

  import dm_reg_pkg::*;

  logic                    req_fire, resp_pop;
  logic                    fifo_full, fifo_empty;
  logic [31:0]             rdata, haltsum0;
  logic [HartSelWidth-1:0] hartsel;
  logic                    haltreq, resumereq, ackhavereset;
  logic                    sel_resumeack;
  dmstatus_t               dmstatus;
  logic [NrHarts-1:0]      slice_halted, slice_running, havereset;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign dmi_req_ready_o  = ~fifo_full;
  assign req_fire         = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_resp_valid_o = ~fifo_empty;
  assign resp_pop         = dmi_resp_valid_o & dmi_resp_ready_i;

  dm_ctrl_regs #(
    .NrHarts (NrHarts)
  ) u_ctrl_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_fire_i        (req_fire),
    .req_op_i          (dmi_req_op_i),
    .req_addr_i        (dmi_req_addr_i),
    .req_data_i        (dmi_req_data_i),
    .dmstatus_i        (dmstatus),
    .haltsum0_i        (haltsum0),
    .sel_resumeack_i   (sel_resumeack),
    .rdata_o           (rdata),
    .hartsel_o         (hartsel),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .ackhavereset_o    (ackhavereset),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .clear_resumeack_o (clear_resumeack_o)
  );

  // one slice per hart
  for (genvar h = 0; h < NrHarts; h++) begin : g_hart
    dm_hart_slice #(
      .HartIdx (h)
    ) u_slice (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .hartsel_i      (hartsel),
      .haltreq_i      (haltreq),
      .resumereq_i    (resumereq),
      .ackhavereset_i (ackhavereset),
      .ndmreset_i     (ndmreset_o),
      .halted_i       (halted_i[h]),
      .unavailable_i  (unavailable_i[h]),
      .resumeack_i    (resumeack_i[h]),
      .haltreq_o      (haltreq_o[h]),
      .resumereq_o    (resumereq_o[h]),
      .havereset_o    (havereset[h]),
      .halted_o       (slice_halted[h]),
      .running_o      (slice_running[h])
    );
  end

  dm_status_gather #(
    .NrHarts (NrHarts)
  ) u_status_gather (
    .hartsel_i       (hartsel),
    .halted_i        (slice_halted),
    .running_i       (slice_running),
    .unavailable_i   (unavailable_i),
    .resumeack_i     (resumeack_i),
    .havereset_i     (havereset),
    .dmstatus_o      (dmstatus),
    .haltsum0_o      (haltsum0),
    .sel_resumeack_o (sel_resumeack)
  );

  dmi_resp_fifo #(
    .RespDepth (RespDepth)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_fire),
    .data_i  (rdata),
    .full_o  (fifo_full),
    .pop_i   (resp_pop),
    .data_o  (dmi_resp_data_o),
    .empty_o (fifo_empty)
  );

endmodule

// File: logic/dmi_pkg.sv
package dmi_pkg;

  // --------------------------------------------------
  // debug module interface transport
  // --------------------------------------------------

  // request address and data word
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // request operation, same code points as the DTM dmi register
  typedef enum logic [1:0] {
    DmiNop   = 2'h0,
    DmiRead  = 2'h1,
    DmiWrite = 2'h2
  } dmi_op_e;

  // 2'h3 is reserved and treated like a nop

endpackage

// File: logic/dmi_resp_fifo.sv
`timescale 1ns/100ps

module dmi_resp_fifo #(
  parameter int unsigned RespDepth = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0]  data_i,
  output logic                              full_o,
  input  logic                              pop_i,
  output logic [dmi_pkg::DmiDataWidth-1:0]  data_o,
  output logic                              empty_o
);

  localparam int unsigned PtrWidth = (RespDepth > 1) ? $clog2(RespDepth) : 1;
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(RespDepth - 1);

  logic [dmi_pkg::DmiDataWidth-1:0] mem_q [RespDepth];
  logic [PtrWidth-1:0]              wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]                count_q;
  logic                             do_push, do_pop;

  assign full_o  = (count_q == (PtrWidth + 1)'(RespDepth));
  assign empty_o = (count_q == '0);

  // drop a push into a full queue and a pop from an empty one
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // first word fall-through
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: project.f
logic/dmi_pkg.sv
logic/dm_reg_pkg.sv
logic/dmi_resp_fifo.sv
logic/dm_ctrl_regs.sv
logic/dm_hart_slice.sv
logic/dm_status_gather.sv
logic/dm_top.sv
sim/tb_dm_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the dm_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_dm_top -o sim_dm_top
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_dm_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

// File: sim/tb_dm_top.sv
`timescale 1ns/100ps

module tb_dm_top;

  import dmi_pkg::*;
  import dm_reg_pkg::*;

  localparam int NrHarts   = 4;
  localparam int RespDepth = 2;
  localparam int MaxCycles = 3000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  logic [6:0]  req_addr;
  dmi_op_e     req_op;
  logic [31:0] req_data;
  logic        resp_valid;
  logic        resp_ready;
  logic [31:0] resp_data;
  logic [3:0]  halted, unavail, resumeack;
  logic [3:0]  haltreq, resumereq;
  logic        ndmreset, dmactive, clear_resumeack;

  // reference model state
  logic        m_dmactive, m_ndmreset, m_haltreq, m_resumereq;
  logic [19:0] m_hartsel;
  logic [3:0]  m_havereset;
  logic [31:0] sb_q[$];
  logic [31:0] exp_head;
  int          exp_count;

  logic        sel_ok, req_fire, exp_clear;
  logic [3:0]  sel_mask, exp_haltreq, exp_resumereq;

  int          bp_mode = 0;
  int          mismatch_count = 0;
  int          other_errors = 0;
  int          cycles = 0;
  logic [31:0] lfsr_q = 32'h42cc_e532;

  dm_top #(
    .NrHarts   (NrHarts),
    .RespDepth (RespDepth)
  ) u_dm_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .dmi_req_valid_i   (req_valid),
    .dmi_req_ready_o   (req_ready),
    .dmi_req_addr_i    (req_addr),
    .dmi_req_op_i      (req_op),
    .dmi_req_data_i    (req_data),
    .dmi_resp_valid_o  (resp_valid),
    .dmi_resp_ready_i  (resp_ready),
    .dmi_resp_data_o   (resp_data),
    .halted_i          (halted),
    .unavailable_i     (unavail),
    .resumeack_i       (resumeack),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .ndmreset_o        (ndmreset),
    .dmactive_o        (dmactive),
    .clear_resumeack_o (clear_resumeack)
  );

  always #10 clk = ~clk;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // standard dmcontrol layout
  function automatic logic [31:0] ctrl_word(input logic act, input logic [19:0] sel,
                                            input logic hreq, input logic rreq,
                                            input logic ack, input logic ndm);
    return {hreq, rreq, 1'b0, ack, 2'b00, sel[9:0], sel[19:10], 4'h0, ndm, act};
  endfunction

  // expected response word from the model state
  function automatic logic [31:0] exp_rdata(input dmi_op_e op, input logic [6:0] addr);
    logic [31:0] w;
    logic [1:0]  s;
    logic        ok;
    w  = '0;
    s  = m_hartsel[1:0];
    ok = (m_hartsel < 20'(NrHarts));
    if (op == DmiRead) begin
      case (addr)
        DMControl: w = ctrl_word(m_dmactive, m_hartsel, m_haltreq, m_resumereq, 1'b0,
                                 m_ndmreset);
        DMStatus: begin
          w[3:0] = 4'h2;
          w[7]   = 1'b1;
          if (ok) begin
            w[9:8]   = {2{halted[s] & ~unavail[s]}};
            w[11:10] = {2{~halted[s] & ~unavail[s]}};
            w[13:12] = {2{unavail[s]}};
            w[17:16] = {2{resumeack[s]}};
            w[19:18] = {2{m_havereset[s]}};
          end else begin
            w[15:14] = 2'b11;
          end
        end
        HaltSum0: begin
          if (m_hartsel[19:5] == 15'd0) begin
            w[3:0] = halted & ~unavail;
          end
        end
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  assign sel_ok        = (m_hartsel < 20'(NrHarts));
  assign sel_mask      = sel_ok ? (4'b0001 << m_hartsel[1:0]) : 4'b0000;
  assign exp_haltreq   = m_haltreq ? sel_mask : 4'b0000;
  assign exp_resumereq = m_resumereq ? (sel_mask & ~resumeack) : 4'b0000;
  assign req_fire      = req_valid && (exp_count < RespDepth);
  assign exp_clear     = req_fire && (req_op == DmiWrite) && (req_addr == DMControl)
                         && m_dmactive && !m_resumereq && req_data[30];

  // --------------------------------------------------
  // reference model and scoreboard
  // --------------------------------------------------
  always @(posedge clk or negedge rst_n) begin : model_update
    logic        ctrl_wr;
    logic [31:0] d;
    if (!rst_n) begin
      m_dmactive  <= 1'b0;
      m_ndmreset  <= 1'b0;
      m_haltreq   <= 1'b0;
      m_resumereq <= 1'b0;
      m_hartsel   <= '0;
      m_havereset <= '1;
      sb_q.delete();
      exp_head    <= '0;
      exp_count   <= 0;
    end else begin
      d       = req_data;
      ctrl_wr = req_fire && (req_op == DmiWrite) && (req_addr == DMControl);
      if (exp_count != 0 && resp_ready) begin
        void'(sb_q.pop_front());
      end
      if (req_fire) begin
        sb_q.push_back(exp_rdata(req_op, req_addr));
      end
      exp_count <= sb_q.size();
      exp_head  <= (sb_q.size() != 0) ? sb_q[0] : '0;
      if (!m_dmactive) begin
        m_dmactive  <= ctrl_wr && d[0];
        m_ndmreset  <= 1'b0;
        m_haltreq   <= 1'b0;
        m_resumereq <= 1'b0;
        m_hartsel   <= '0;
      end else begin
        if (ctrl_wr) begin
          m_haltreq  <= d[31];
          m_ndmreset <= d[1];
          m_dmactive <= d[0];
          m_hartsel  <= {d[15:6], d[25:16]};
        end
        // ack from the selected hart wins over a new write
        if (m_resumereq && sel_ok && resumeack[m_hartsel[1:0]]) begin
          m_resumereq <= 1'b0;
        end else if (ctrl_wr) begin
          m_resumereq <= d[30];
        end
      end
      if (m_ndmreset) begin
        m_havereset <= '1;
      end else if (ctrl_wr && m_dmactive && d[28] && sel_ok) begin
        m_havereset[m_hartsel[1:0]] <= 1'b0;
      end
    end
  end

  task automatic report_mismatch(input string msg);
    mismatch_count++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  ready_follows_count: assert property (@(posedge clk) disable iff (!rst_n)
      req_ready == (exp_count < RespDepth))
    else report_mismatch("request ready does not follow the number of queued responses");

  valid_follows_count: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid == (exp_count != 0))
    else report_mismatch("response valid lost or duplicated a response");

  resp_in_order: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid && resp_ready) |-> (resp_data == exp_head))
    else report_mismatch("response word differs from the scoreboard");

  haltreq_steering: assert property (@(posedge clk) disable iff (!rst_n)
      haltreq == exp_haltreq)
    else report_mismatch("haltreq_o does not match the selected hart");

  resumereq_steering: assert property (@(posedge clk) disable iff (!rst_n)
      resumereq == exp_resumereq)
    else report_mismatch("resumereq_o does not match the selected hart");

  clear_resumeack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      clear_resumeack == exp_clear)
    else report_mismatch("clear_resumeack_o pulse wrong");

  ctrl_outputs: assert property (@(posedge clk) disable iff (!rst_n)
      (dmactive == m_dmactive) && (ndmreset == m_ndmreset))
    else report_mismatch("dmactive_o or ndmreset_o wrong");

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic finish_run(input bit timed_out);
    if (timed_out) begin
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", MaxCycles);
      finish_run(1'b1);
    end
  end

  // response ready held high, gapped at random or held low
  always @(negedge clk) begin
    case (bp_mode)
      0: resp_ready = 1'b1;
      1: resp_ready = (rand_bits(2) != 32'd0);
      default: resp_ready = 1'b0;
    endcase
  end

  // starts on a falling edge and returns on the falling edge after acceptance
  task automatic send_req(input dmi_op_e op, input logic [6:0] addr, input logic [31:0] data);
    logic accepted;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_data  = data;
    do begin
      accepted = req_ready;
      @(negedge clk);
    end while (!accepted);
    req_valid = 1'b0;
    req_op    = DmiNop;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = DmiNop;
    req_addr   = '0;
    req_data   = '0;
    resp_ready = 1'b1;
    halted     = '0;
    unavail    = '0;
    resumeack  = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    idle(2);

    // state after reset
    send_req(DmiRead, DMControl, '0);
    send_req(DmiRead, DMStatus, '0);

    // haltreq needs dmactive and only reaches the selected hart
    send_req(DmiWrite, DMControl, ctrl_word(1'b0, 20'd1, 1'b1, 1'b0, 1'b0, 1'b0));
    idle(2);
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd0, 1'b0, 1'b0, 1'b0, 1'b0));
    for (int k = 0; k < 6; k++) begin
      send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'(k), 1'b1, 1'b0, 1'b0, 1'b0));
      idle(2);
      send_req(DmiRead, DMStatus, '0);
    end
    // halted harts outside the addressed haltsum0 group
    halted = 4'b0101;
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'h00400, 1'b1, 1'b0, 1'b0, 1'b0));
    send_req(DmiRead, HaltSum0, '0);
    send_req(DmiRead, DMControl, '0);

    // random hart status
    for (int i = 0; i < 30; i++) begin
      halted    = 4'(rand_bits(4));
      unavail   = 4'(rand_bits(4));
      resumeack = 4'(rand_bits(4));
      send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'(rand_bits(3)), 1'b0, 1'b0, 1'b0, 1'b0));
      send_req(DmiRead, DMStatus, '0);
      send_req(DmiRead, HaltSum0, '0);
    end
    halted    = '0;
    unavail   = '0;
    resumeack = '0;

    // ackhavereset clears one hart and ndmreset sets all again
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd2, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd2, 1'b0, 1'b0, 1'b1, 1'b0));
    send_req(DmiRead, DMStatus, '0);
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd1, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(DmiRead, DMStatus, '0);
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd2, 1'b0, 1'b0, 1'b0, 1'b1));
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd2, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(DmiRead, DMStatus, '0);

    // resume request and its acknowledge
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd1, 1'b0, 1'b1, 1'b0, 1'b0));
    idle(3);
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd1, 1'b0, 1'b1, 1'b0, 1'b0));
    resumeack = 4'b0010;
    idle(3);
    send_req(DmiRead, DMStatus, '0);
    resumeack = '0;
    idle(2);

    // back-pressure on responses
    bp_mode = 2;
    send_req(DmiRead, DMControl, '0);
    send_req(DmiRead, DMStatus, '0);
    idle(4);
    bp_mode = 1;
    for (int i = 0; i < 24; i++) begin
      case (i % 4)
        0: send_req(DmiRead, DMControl, '0);
        1: send_req(DmiRead, DMStatus, '0);
        2: send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'(i % 5), 1'b1, 1'b0, 1'b0, 1'b0));
        default: send_req(DmiRead, 7'h05, '0);
      endcase
    end
    bp_mode = 0;
    while (resp_valid) begin
      @(negedge clk);
    end

    // inactive again so only dmactive may be written
    send_req(DmiWrite, DMControl, ctrl_word(1'b0, 20'd0, 1'b0, 1'b0, 1'b0, 1'b0));
    send_req(DmiWrite, DMControl, ctrl_word(1'b1, 20'd2, 1'b1, 1'b1, 1'b0, 1'b1));
    send_req(DmiRead, DMControl, '0);
    while (resp_valid) begin
      @(negedge clk);
    end
    idle(2);
    finish_run(1'b0);
  end

endmodule
